// ==== strand_control.f ====
hw/cr_pkg.sv
hw/isa_pkg.sv
hw/issue_stage.sv
hw/execute_stage.sv
hw/control_registers.sv
hw/writeback_stage.sv
hw/strand_control_top.sv
bench/strand_control_tb.sv

// ==== Makefile ====
# Verilator build and run of the strand control testbench

VERILATOR ?= verilator
TOP ?= strand_control_tb
FILELIST ?= strand_control.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_TEXT ?= All tests passed

.PHONY: simulate clean

# Builds, runs, and fails unless the pass line shows up
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/strand_control_tb.sv ====
/* Strand control testbench
   Random control register traffic checked against a cycle model of the pipeline */

module strand_control_tb
	import cr_pkg::*, isa_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CORE_ID = 3;
	localparam int SEED = 71684;
	localparam int CLK_HALF = 4;

	// Run length budget with a fixed allowance per directed part
	localparam int DIRECT_BUDGET = 64;
	localparam int TEST2_OPS = 300;
	localparam int TEST3_OPS = 200;
	localparam int TEST4_ROUNDS = 4;
	localparam int TEST4_OPS = 150;
	localparam int TEST5_OPS = 60;
	localparam int MAX_CYCLES = 5 * DIRECT_BUDGET + TEST2_OPS + TEST3_OPS
		+ TEST4_ROUNDS * (TEST4_OPS + DIRECT_BUDGET) + TEST5_OPS + 100;

	// Expected output kinds per cycle
	localparam int EXP_NONE = 0;
	localparam int EXP_RESULT = 1;
	localparam int EXP_REDIRECT = 2;

	logic clk = 1'b0;
	logic reset;
	logic op_valid;
	op_t op_code;
	strand_t op_strand;
	cr_index_t op_index;
	word_t op_value;
	logic result_valid;
	strand_t result_strand;
	word_t result_value;
	logic redirect_valid;
	strand_t redirect_strand;
	word_t redirect_pc;
	strand_mask_t strand_enable;

	// Model of the register state after the last edge
	strand_mask_t m_mask;
	word_t m_handler;
	word_t m_pc [4];

	// Op accepted at issue and applied at the next edge
	logic p_valid;
	op_t p_code;
	strand_t p_strand;
	cr_index_t p_index;
	word_t p_value;

	// One entry per cycle with the head due now
	int exp_kind [$];
	strand_t exp_strand [$];
	word_t exp_value [$];

	int error_count = 0;
	int check_count = 0;
	int tests_run = 0;
	int mark = 0;
	int cycle_count = 0;

	strand_control_top #(.CORE_ID(CORE_ID)) DUT (
		.clk, .reset, .op_valid, .op_code, .op_strand, .op_index, .op_value,
		.result_valid, .result_strand, .result_value,
		.redirect_valid, .redirect_strand, .redirect_pc, .strand_enable
	);

	initial
	begin
		forever #CLK_HALF clk = ~clk;
	end

	// Hard stop in case the run never ends
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("Timeout: run passed %0d cycles without finishing", MAX_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	// Register read as the register map defines it
	function automatic word_t expected_read(input cr_index_t index, input strand_t strand);
		case (index)
			CR_STRAND_ID:         return {30'(CORE_ID), strand};
			CR_EXCEPTION_HANDLER: return m_handler;
			CR_FAULT_ADDRESS:     return m_pc[strand];
			CR_STRAND_ENABLE:     return {28'd0, m_mask};
			default:              return '0;
		endcase
	endfunction

	task automatic check_value(input string what, input word_t actual, input word_t expected);
		check_count = check_count + 1;
		if (actual !== expected)
		begin
			error_count = error_count + 1;
			$display("Error at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic push_expect(input int kind, input strand_t strand, input word_t value);
		exp_kind.push_back(kind);
		exp_strand.push_back(strand);
		exp_value.push_back(value);
	endtask

	task automatic model_reset();
		m_mask = STRAND_ENABLE_RESET;
		m_handler = '0;
		for (int i = 0; i < 4; i++)
			m_pc[i] = '0;
		p_valid = 1'b0;
		exp_kind.delete();
		exp_strand.delete();
		exp_value.delete();
		// Pipeline is empty for two cycles
		push_expect(EXP_NONE, '0, '0);
		push_expect(EXP_NONE, '0, '0);
	endtask

	// Strobes against the queue head and payload only under a strobe
	task automatic compare_outputs();
		int kind;
		strand_t strand;
		word_t value;
		kind = exp_kind.pop_front();
		strand = exp_strand.pop_front();
		value = exp_value.pop_front();
		if (kind == EXP_RESULT && result_valid !== 1'b1)
		begin
			error_count = error_count + 1;
			$display("Missing read result for strand %0d at %0d ns", strand, $time);
		end
		else if (kind != EXP_RESULT && result_valid !== 1'b0)
		begin
			error_count = error_count + 1;
			$display("Unexpected read result from strand %0d at %0d ns", result_strand, $time);
		end
		else if (kind == EXP_RESULT)
		begin
			check_value("result_strand", word_t'(result_strand), word_t'(strand));
			check_value("result_value", result_value, value);
		end
		if (kind == EXP_REDIRECT && redirect_valid !== 1'b1)
		begin
			error_count = error_count + 1;
			$display("Missing redirect for strand %0d at %0d ns", strand, $time);
		end
		else if (kind != EXP_REDIRECT && redirect_valid !== 1'b0)
		begin
			error_count = error_count + 1;
			$display("Unexpected redirect for strand %0d at %0d ns", redirect_strand, $time);
		end
		else if (kind == EXP_REDIRECT)
		begin
			check_value("redirect_strand", word_t'(redirect_strand), word_t'(strand));
			check_value("redirect_pc", redirect_pc, value);
		end
	endtask

	// One clock of checking and one model edge before the next op
	task automatic run_cycle(input logic valid, input op_t code, input strand_t strand,
		input cr_index_t index, input word_t value);
		logic accept;
		@(negedge clk);
		compare_outputs();
		check_value("strand_enable", word_t'(strand_enable), word_t'(m_mask));
		// Issue sees the mask before the pending op lands
		accept = valid && m_mask[strand];
		if (p_valid && p_code == OP_CR_READ)
			push_expect(EXP_RESULT, p_strand, expected_read(p_index, p_strand));
		else if (p_valid && p_code == OP_FAULT)
		begin
			m_pc[p_strand] = p_value;
			push_expect(EXP_REDIRECT, p_strand, m_handler);
		end
		else
		begin
			if (p_valid && p_code == OP_CR_WRITE && p_index == CR_EXCEPTION_HANDLER)
				m_handler = p_value;
			else if (p_valid && p_code == OP_CR_WRITE && p_index == CR_STRAND_ENABLE)
				m_mask = p_value[3:0];
			else if (p_valid && p_code == OP_CR_WRITE && p_index == CR_HALT)
				m_mask = '0;
			push_expect(EXP_NONE, '0, '0);
		end
		p_valid = accept;
		p_code = code;
		p_strand = strand;
		p_index = index;
		p_value = value;
		op_valid = valid;
		op_code = code;
		op_strand = strand;
		op_index = index;
		op_value = value;
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) run_cycle(1'b0, OP_NOP, '0, '0, '0);
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		op_valid = 1'b0;
		op_code = OP_NOP;
		op_strand = '0;
		op_index = '0;
		op_value = '0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		model_reset();
	endtask

	task automatic finish_test(input string name);
		tests_run = tests_run + 1;
		$display("Test %0d %s finished with %0d errors", tests_run, name, error_count - mark);
		mark = error_count;
	endtask

	// Mask word with at least one strand left running
	function automatic word_t nonzero_mask_word();
		word_t v;
		v = $urandom;
		v[3:0] = 4'($urandom_range(1, 15));
		return v;
	endfunction

	// Mostly mapped indices with halt kept rare
	function automatic cr_index_t pick_index();
		int r;
		r = $urandom_range(0, 99);
		if (r < 20)
			return CR_STRAND_ID;
		else if (r < 40)
			return CR_EXCEPTION_HANDLER;
		else if (r < 60)
			return CR_FAULT_ADDRESS;
		else if (r < 85)
			return CR_STRAND_ENABLE;
		else if (r < 87)
			return CR_HALT;
		return cr_index_t'($urandom_range(3, 29));
	endfunction

	task automatic random_cycle();
		cr_index_t index;
		word_t value;
		index = pick_index();
		value = (index == CR_STRAND_ENABLE) ? nonzero_mask_word() : word_t'($urandom);
		run_cycle($urandom_range(0, 9) != 0, op_t'($urandom_range(0, 3)),
			strand_t'($urandom_range(0, 3)), index, value);
	endtask

	task automatic test_after_reset();
		run_cycle(1'b1, OP_CR_READ, 2'd0, CR_STRAND_ENABLE, '0);
		run_cycle(1'b1, OP_CR_READ, 2'd0, CR_STRAND_ID, '0);
		// Nothing from the stopped strands may land
		for (int s = 1; s < 4; s++)
		begin
			run_cycle(1'b1, OP_CR_READ, strand_t'(s), CR_STRAND_ID, '0);
			run_cycle(1'b1, OP_FAULT, strand_t'(s), '0, $urandom);
			run_cycle(1'b1, OP_CR_WRITE, strand_t'(s), CR_EXCEPTION_HANDLER, $urandom);
		end
		run_cycle(1'b1, OP_CR_READ, 2'd0, CR_EXCEPTION_HANDLER, '0);
		idle_cycles(3);
		finish_test("after reset");
	endtask

	task automatic test_handler_and_mask();
		int r;
		for (int i = 0; i < TEST2_OPS; i++)
		begin
			r = $urandom_range(0, 3);
			if (r == 0)
				run_cycle(1'b1, OP_CR_WRITE, 2'd0, CR_EXCEPTION_HANDLER, $urandom);
			else if (r == 1)
				// Strand 0 keeps itself running
				run_cycle(1'b1, OP_CR_WRITE, 2'd0, CR_STRAND_ENABLE, $urandom | 32'h1);
			else if (r == 2)
				run_cycle(1'b1, OP_CR_READ, 2'd0,
					$urandom_range(0, 1) ? CR_EXCEPTION_HANDLER : CR_STRAND_ENABLE, '0);
			else
				run_cycle(1'b1, OP_CR_READ, 2'd0,
					$urandom_range(0, 3) == 0 ? CR_HALT : cr_index_t'($urandom_range(3, 29)), '0);
		end
		idle_cycles(3);
		finish_test("handler and mask");
	endtask

	task automatic test_faults();
		int r;
		run_cycle(1'b1, OP_CR_WRITE, 2'd0, CR_STRAND_ENABLE, 32'hF);
		run_cycle(1'b1, OP_CR_WRITE, 2'd0, CR_EXCEPTION_HANDLER, $urandom);
		for (int i = 0; i < TEST3_OPS; i++)
		begin
			r = $urandom_range(0, 9);
			if (r < 8)
				run_cycle(1'b1, OP_FAULT, strand_t'($urandom_range(0, 3)), '0, $urandom & ~32'h3);
			else if (r == 8)
				run_cycle(1'b1, OP_CR_WRITE, strand_t'($urandom_range(0, 3)),
					CR_EXCEPTION_HANDLER, $urandom);
			else
				run_cycle(1'b1, OP_CR_READ, strand_t'($urandom_range(0, 3)), CR_FAULT_ADDRESS, '0);
		end
		for (int s = 0; s < 4; s++)
			run_cycle(1'b1, OP_CR_READ, strand_t'(s), CR_FAULT_ADDRESS, '0);
		idle_cycles(3);
		finish_test("faults");
	endtask

	task automatic test_random_mix();
		int halt_strand;
		for (int round = 0; round < TEST4_ROUNDS; round++)
		begin
			apply_reset();
			repeat (TEST4_OPS) random_cycle();
			idle_cycles(2);
			// Halt from any strand still running
			halt_strand = -1;
			for (int s = 3; s >= 0; s--)
				if (m_mask[s])
					halt_strand = s;
			if (halt_strand >= 0)
				run_cycle(1'b1, OP_CR_WRITE, strand_t'(halt_strand), CR_HALT, $urandom);
			idle_cycles(2);
			check_value("mask after halt", word_t'(strand_enable), '0);
			// Everything after the halt is dropped
			repeat (10) random_cycle();
			idle_cycles(3);
		end
		finish_test("random mix");
	endtask

	task automatic test_reset_mid_run();
		apply_reset();
		run_cycle(1'b1, OP_CR_WRITE, 2'd0, CR_STRAND_ENABLE, 32'hF);
		run_cycle(1'b1, OP_CR_WRITE, 2'd0, CR_EXCEPTION_HANDLER, $urandom);
		repeat (TEST5_OPS)
			run_cycle(1'b1, $urandom_range(0, 3) == 0 ? OP_CR_READ : OP_FAULT,
				strand_t'($urandom_range(0, 3)), CR_FAULT_ADDRESS, $urandom);
		// Ops still in flight are lost
		apply_reset();
		run_cycle(1'b1, OP_CR_READ, 2'd0, CR_EXCEPTION_HANDLER, '0);
		run_cycle(1'b1, OP_CR_READ, 2'd0, CR_FAULT_ADDRESS, '0);
		run_cycle(1'b1, OP_CR_READ, 2'd0, CR_STRAND_ENABLE, '0);
		// Other strands start again so their cleared PCs can be read
		run_cycle(1'b1, OP_CR_WRITE, 2'd0, CR_STRAND_ENABLE, 32'hF);
		idle_cycles(1);
		for (int s = 1; s < 4; s++)
			run_cycle(1'b1, OP_CR_READ, strand_t'(s), CR_FAULT_ADDRESS, '0);
		idle_cycles(3);
		finish_test("reset mid-run");
	endtask

	initial
	begin
		void'($urandom(SEED));
		apply_reset();
		test_after_reset();
		test_handler_and_mask();
		test_faults();
		test_random_mix();
		test_reset_mid_run();
		$display("Ran %0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== hw/strand_control_top.sv ====
/* Strand control top level
   Three-stage control register pipeline around the control register block */

module strand_control_top
	import cr_pkg::*, isa_pkg::*;
#(
	parameter int CORE_ID = 0
)
(
	input  logic         clk,
	input  logic         reset,

	// Operation stream in
	input  logic         op_valid,
	input  op_t          op_code,
	input  strand_t      op_strand,
	input  cr_index_t    op_index,
	input  word_t        op_value,

	// Read results
	output logic         result_valid,
	output strand_t      result_strand,
	output word_t        result_value,

	// Fault redirects
	output logic         redirect_valid,
	output strand_t      redirect_strand,
	output word_t        redirect_pc,

	// Live enable mask
	output strand_mask_t strand_enable
);

	// Issue to execute
	logic      is_valid;
	op_t       is_code;
	strand_t   is_strand;
	cr_index_t is_index;
	word_t     is_value;

	// Execute to and from the register block
	logic      cr_read_en;
	logic      cr_write_en;
	logic      latch_fault;
	strand_t   ex_strand;
	cr_index_t cr_index;
	word_t     cr_write_value;
	word_t     fault_pc;
	strand_t   fault_strand;
	word_t     cr_read_value;
	word_t     exception_handler_address;

	// Execute to writeback
	logic      ex_valid;
	op_t       ex_code;
	strand_t   ex_strand_q;
	word_t     ex_read_value;

	issue_stage u_issue (
		.clk, .reset, .op_valid, .op_code, .op_strand, .op_index, .op_value,
		.strand_enable, .is_valid, .is_code, .is_strand, .is_index, .is_value
	);

	execute_stage u_execute (
		.clk, .reset, .is_valid, .is_code, .is_strand, .is_index, .is_value,
		.cr_read_value, .cr_read_en, .cr_write_en, .latch_fault, .ex_strand,
		.cr_index, .cr_write_value, .fault_pc, .fault_strand,
		.ex_valid, .ex_code, .ex_strand_q, .ex_read_value
	);

	// Core number only shows up in the strand ID read
	control_registers #(.CORE_ID(CORE_ID)) u_control_registers (
		.clk, .reset, .latch_fault, .fault_pc, .fault_strand, .ex_strand,
		.cr_index, .cr_read_en, .cr_write_en, .cr_write_value,
		.strand_enable, .exception_handler_address, .cr_read_value
	);

	writeback_stage u_writeback (
		.clk, .reset, .ex_valid, .ex_code, .ex_strand_q, .ex_read_value,
		.exception_handler_address, .result_valid, .result_strand, .result_value,
		.redirect_valid, .redirect_strand, .redirect_pc
	);

endmodule

// ==== hw/writeback_stage.sv ====
/* Writeback stage
   Turns finished reads into results and finished faults into handler redirects */

module writeback_stage
	import cr_pkg::*, isa_pkg::*;
(
	input  logic    clk,
	input  logic    reset,

	// From execute
	input  logic    ex_valid,
	input  op_t     ex_code,
	input  strand_t ex_strand_q,
	input  word_t   ex_read_value,

	// Handler as it stands after the previous edge
	input  word_t   exception_handler_address,

	// Read results
	output logic    result_valid,
	output strand_t result_strand,
	output word_t   result_value,

	// Fault redirects
	output logic    redirect_valid,
	output strand_t redirect_strand,
	output word_t   redirect_pc
);

	// Writes and nops end here silently
	logic finish_read;
	logic finish_fault;

	assign finish_read = ex_valid && ex_code == OP_CR_READ;
	assign finish_fault = ex_valid && ex_code == OP_FAULT;

	// Single-cycle strobes, never both at once
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			result_valid <= 1'b0;
			redirect_valid <= 1'b0;
		end
		else
		begin
			result_valid <= finish_read;
			redirect_valid <= finish_fault;
		end
	end

	// Payloads only meaningful under their strobe
	always_ff @(posedge clk)
	begin
		result_strand <= ex_strand_q;
		result_value <= ex_read_value;
		redirect_strand <= ex_strand_q;
		// Picks up any handler write made by the op just ahead
		redirect_pc <= exception_handler_address;
	end

endmodule

// ==== hw/control_registers.sv ====
/* Control register block
   Strand enable mask, exception handler address and per-strand saved fault PCs */

module control_registers
	import cr_pkg::*, isa_pkg::*;
#(
	parameter int CORE_ID = 0
)
(
	input  logic         clk,
	input  logic         reset,

	// Fault capture from execute
	input  logic         latch_fault,
	input  word_t        fault_pc,
	input  strand_t      fault_strand,

	// Register access from execute
	input  strand_t      ex_strand,
	input  cr_index_t    cr_index,
	input  logic         cr_read_en,
	input  logic         cr_write_en,
	input  word_t        cr_write_value,

	// State out to the pipeline
	output strand_mask_t strand_enable,
	output word_t        exception_handler_address,
	output word_t        cr_read_value
);

	// One saved PC per strand
	word_t saved_fault_pc [STRAND_COUNT];

	// Read mux
	// Nothing drives the bus unless a read is under way
	always_comb
	begin
		cr_read_value = '0;
		if (cr_read_en)
		begin
			case (cr_index)
				// Core number sits above the strand bits
				CR_STRAND_ID:
					cr_read_value = {(WORD_WIDTH - STRAND_WIDTH)'(CORE_ID), ex_strand};
				CR_EXCEPTION_HANDLER:
					cr_read_value = exception_handler_address;
				CR_FAULT_ADDRESS:
					cr_read_value = saved_fault_pc[ex_strand];
				CR_STRAND_ENABLE:
					cr_read_value = word_t'(strand_enable);
				// Unknown indices read zero
				default:
					cr_read_value = '0;
			endcase
		end
	end

	// Write decode and fault capture
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			strand_enable <= STRAND_ENABLE_RESET;
			exception_handler_address <= '0;
			for (int i = 0; i < STRAND_COUNT; i++)
				saved_fault_pc[i] <= '0;
		end
		else
		begin
			if (cr_write_en)
			begin
				case (cr_index)
					CR_EXCEPTION_HANDLER:
						exception_handler_address <= cr_write_value;
					// Low bits only, one per strand
					CR_STRAND_ENABLE:
						strand_enable <= cr_write_value[STRAND_COUNT-1:0];
					// Written value ignored
					CR_HALT:
						strand_enable <= '0;
					default:
						;
				endcase
			end

			// Last fault of each strand wins
			if (latch_fault)
				saved_fault_pc[fault_strand] <= fault_pc;
		end
	end

endmodule

// ==== hw/execute_stage.sv ====
/* Execute stage
   Decodes each op into one control register strobe and captures read data */

module execute_stage
	import cr_pkg::*, isa_pkg::*;
(
	input  logic      clk,
	input  logic      reset,

	// From issue
	input  logic      is_valid,
	input  op_t       is_code,
	input  strand_t   is_strand,
	input  cr_index_t is_index,
	input  word_t     is_value,

	// Read data back from the register block
	input  word_t     cr_read_value,

	// To the register block
	output logic      cr_read_en,
	output logic      cr_write_en,
	output logic      latch_fault,
	output strand_t   ex_strand,
	output cr_index_t cr_index,
	output word_t     cr_write_value,
	output word_t     fault_pc,
	output strand_t   fault_strand,

	// To writeback
	output logic      ex_valid,
	output op_t       ex_code,
	output strand_t   ex_strand_q,
	output word_t     ex_read_value
);

	// One strobe per op code
	// A nop raises none of them
	logic is_read;
	logic is_write;
	logic is_fault;

	assign is_read = is_code == OP_CR_READ;
	assign is_write = is_code == OP_CR_WRITE;
	assign is_fault = is_code == OP_FAULT;

	// Strobes are exclusive since the code picks exactly one
	assign cr_read_en = is_valid && is_read;
	assign cr_write_en = is_valid && is_write;
	assign latch_fault = is_valid && is_fault;

	// Register access fields
	assign ex_strand = is_strand;
	assign cr_index = is_index;
	assign cr_write_value = is_value;

	// Fault capture fields
	// Same value slot carries the PC
	assign fault_pc = is_value;
	assign fault_strand = is_strand;

	// Valid bit into writeback
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ex_valid <= 1'b0;
		else
			ex_valid <= is_valid;
	end

	// Op identity and read data for writeback
	always_ff @(posedge clk)
	begin
		ex_code <= is_code;
		ex_strand_q <= is_strand;
		ex_read_value <= cr_read_value;
	end

endmodule

// ==== hw/issue_stage.sv ====
/* Issue stage
   First register bank, squashes operations from disabled strands */

module issue_stage
	import cr_pkg::*, isa_pkg::*;
(
	input  logic         clk,
	input  logic         reset,

	// Incoming operation stream
	input  logic         op_valid,
	input  op_t          op_code,
	input  strand_t      op_strand,
	input  cr_index_t    op_index,
	input  word_t        op_value,

	// Current mask from the register block
	input  strand_mask_t strand_enable,

	// To execute
	output logic         is_valid,
	output op_t          is_code,
	output strand_t      is_strand,
	output cr_index_t    is_index,
	output word_t        is_value
);

	// Mask as it stands before this edge decides the op
	logic strand_running;

	assign strand_running = strand_enable[op_strand];

	// Valid bit is control state
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			is_valid <= 1'b0;
		else
			is_valid <= op_valid && strand_running;
	end

	// Payload only moves when something arrives
	always_ff @(posedge clk)
	begin
		if (op_valid)
		begin
			is_code <= op_code;
			is_strand <= op_strand;
			is_index <= op_index;
			is_value <= op_value;
		end
	end

endmodule

// ==== hw/isa_pkg.sv ====
/* Operation encoding package
   Control-register operation codes carried down the pipeline */

package isa_pkg;

	// Width of the operation code field
	localparam int OP_WIDTH = 2;

	// Raw operation field
	typedef logic [OP_WIDTH-1:0] op_bits_t;

	// Operation codes
	// A nop travels like any other op but touches nothing
	typedef enum op_bits_t
	{
		OP_NOP      = 2'd0,
		OP_CR_READ  = 2'd1,
		OP_CR_WRITE = 2'd2,
		// Value field holds the faulting PC
		OP_FAULT    = 2'd3
	} op_t;

endpackage

// ==== hw/cr_pkg.sv ====
/* Control register package
   Data widths, strand types and register index map of the strand-control slice */

package cr_pkg;

	// Machine word and strand geometry
	localparam int WORD_WIDTH = 32;
	localparam int STRAND_COUNT = 4;
	localparam int STRAND_WIDTH = $clog2(STRAND_COUNT);
	localparam int CR_INDEX_WIDTH = 5;

	// Register values, PCs and read data
	typedef logic [WORD_WIDTH-1:0] word_t;

	// Strand number within the core
	typedef logic [STRAND_WIDTH-1:0] strand_t;

	// One enable bit per strand
	typedef logic [STRAND_COUNT-1:0] strand_mask_t;

	// Control register address
	typedef logic [CR_INDEX_WIDTH-1:0] cr_index_t;

	// Core ID above the strand number
	localparam cr_index_t CR_STRAND_ID = 5'd0;
	localparam cr_index_t CR_EXCEPTION_HANDLER = 5'd1;
	// Saved PC of the requesting strand
	localparam cr_index_t CR_FAULT_ADDRESS = 5'd2;
	localparam cr_index_t CR_STRAND_ENABLE = 5'd30;
	// Any write stops every strand
	localparam cr_index_t CR_HALT = 5'd31;

	// Only strand 0 runs out of reset
	localparam strand_mask_t STRAND_ENABLE_RESET = 4'b0001;

endpackage
